// File: vlog.f
+incdir+verilog
verilog/decode_pkg.sv
verilog/control_decoder.sv
verilog/register_file.sv
verilog/hazard_detect.sv
verilog/branch_resolve.sv
verilog/decode_stage.sv
dv/decode_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= decode_stage_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/decode_stage_tb.sv
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_stage_tb
    import decode_pkg::*;
();

    // kinds of instruction sitting in id/ex
    localparam logic [1:0] IDEX_IDLE  = 2'd0;
    localparam logic [1:0] IDEX_ALU   = 2'd1;
    localparam logic [1:0] IDEX_LOAD  = 2'd2;
    localparam logic [1:0] IDEX_STORE = 2'd3;

    logic                  clk            = 1'b0;
    logic                  reset          = 1'b1;
    logic [`WORD_W-1:0]    instr          = {NOP, 11'd0};
    logic [`WORD_W-1:0]    pc             = '0;
    logic [`WORD_W-1:0]    pc_plus_two    = 16'd2;
    logic                  idex_mem_en    = 1'b0;
    logic                  idex_mem_wr    = 1'b0;
    logic                  idex_reg_write = 1'b0;
    logic [`REG_SEL_W-1:0] idex_dst_reg   = '0;
    logic                  wb_write_en    = 1'b0;
    logic [`REG_SEL_W-1:0] wb_dst_reg     = '0;
    logic [`WORD_W-1:0]    wb_data        = '0;
    ctrl_t                 ctrl;
    logic [`WORD_W-1:0]    read1_data;
    logic [`WORD_W-1:0]    read2_data;
    logic [`WORD_W-1:0]    imm_ext;
    logic [`WORD_W-1:0]    next_pc;
    logic                  if_flush;
    logic                  pc_write_en;
    logic                  ifid_write_en;

    logic [31:0]           lcg_state = 32'h5ba9_67e4;
    logic [`WORD_W-1:0]    shadow [`REG_COUNT];
    logic [`WORD_W-1:0]    exp_read1;
    logic [`WORD_W-1:0]    exp_read2;
    logic [`WORD_W-1:0]    exp_imm;
    logic [`WORD_W-1:0]    exp_next_pc;
    logic                  exp_flush;
    logic                  exp_stall;
    ctrl_t                 exp_ctrl;

    decode_stage DUT (.*);

    always #10 clk = ~clk;

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // control word an instruction should carry when not stalled
    function automatic ctrl_t ref_ctrl(input logic [15:0] ins);
        ctrl_t c;
        c = '0;
        case (ins[15:11])
            HALT: c.halt = 1'b1;
            ADDI, SUBI, XORI, ANDNI: begin
                c.reg_write_en = 1'b1;
                c.alu_src_imm  = 1'b1;
                c.dst_reg      = ins[7:5];
                case (ins[15:11])
                    SUBI:    c.alu_op = SUB;
                    XORI:    c.alu_op = XOR;
                    ANDNI:   c.alu_op = ANDN;
                    default: c.alu_op = ADD;
                endcase
            end
            RTYPE: begin
                c.reg_write_en = 1'b1;
                c.alu_op       = alu_op_e'(ins[1:0]);
                c.dst_reg      = ins[4:2];
            end
            LD: begin
                c.reg_write_en = 1'b1;
                c.mem_en       = 1'b1;
                c.alu_src_imm  = 1'b1;
                c.reg_src      = MEM;
                c.dst_reg      = ins[7:5];
            end
            ST: begin
                c.mem_en      = 1'b1;
                c.mem_wr      = 1'b1;
                c.alu_src_imm = 1'b1;
            end
            LBI: begin
                c.reg_write_en = 1'b1;
                c.reg_src      = IMM;
                c.dst_reg      = ins[10:8];
            end
            JAL, JALR: begin
                c.reg_write_en = 1'b1;
                c.reg_src      = PC_PLUS_TWO;
                c.dst_reg      = 3'd7;
            end
            default: c = '0;
        endcase
        return c;
    endfunction

    // {uses rs, uses rt}
    function automatic logic [1:0] reg_use(input logic [15:0] ins);
        case (ins[15:11])
            RTYPE, ST: return 2'b11;
            ADDI, SUBI, XORI, ANDNI, LD, BEQZ, BNEZ, BLTZ, BGEZ, JR, JALR: return 2'b10;
            default: return 2'b00;
        endcase
    endfunction

    function automatic logic ref_stall(input logic [15:0] ins, input logic mem_en, mem_wr,
                                       reg_write, input logic [2:0] dst);
        logic [1:0] use_bits;
        logic       reads_rs_early;
        use_bits = reg_use(ins);
        reads_rs_early = ins[15:11] inside {BEQZ, BNEZ, BLTZ, BGEZ, JR, JALR};
        if (mem_en && !mem_wr &&
            ((use_bits[1] && dst == ins[10:8]) || (use_bits[0] && dst == ins[7:5]))) begin
            return 1'b1;
        end
        return reads_rs_early && reg_write && dst == ins[10:8];
    endfunction

    function automatic logic [15:0] ref_imm(input logic [15:0] ins);
        case (ins[15:11])
            ADDI, SUBI, ST, LD: return {{11{ins[4]}}, ins[4:0]};
            XORI, ANDNI: return {11'd0, ins[4:0]};
            LBI, BEQZ, BNEZ, BLTZ, BGEZ, JR, JALR: return {{8{ins[7]}}, ins[7:0]};
            J, JAL: return {{5{ins[10]}}, ins[10:0]};
            default: return '0;
        endcase
    endfunction

    // {flush, target} for an instruction that is not stalled
    function automatic logic [16:0] ref_target(input logic [15:0] ins, p, ppt, rsv);
        logic [15:0] off8;
        logic [15:0] off11;
        off8  = {{8{ins[7]}}, ins[7:0]};
        off11 = {{5{ins[10]}}, ins[10:0]};
        case (ins[15:11])
            HALT: return {1'b0, p};
            BEQZ: if (rsv == 16'd0) return {1'b1, ppt + off8};
            BNEZ: if (rsv != 16'd0) return {1'b1, ppt + off8};
            BLTZ: if (rsv[15]) return {1'b1, ppt + off8};
            BGEZ: if (!rsv[15]) return {1'b1, ppt + off8};
            J, JAL: return {1'b1, ppt + off11};
            JR, JALR: return {1'b1, rsv + off8};
            default: ;
        endcase
        return {1'b0, ppt};
    endfunction

    // shadow copy of the register file, fed by the same write-back stimulus
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                shadow[i] <= '0;
            end
        end else if (wb_write_en) begin
            shadow[wb_dst_reg] <= wb_data;
        end
    end

    always_comb begin
        exp_read1 = (wb_write_en && wb_dst_reg == instr[10:8]) ? wb_data : shadow[instr[10:8]];
        exp_read2 = (wb_write_en && wb_dst_reg == instr[7:5]) ? wb_data : shadow[instr[7:5]];
        exp_stall = ref_stall(instr, idex_mem_en, idex_mem_wr, idex_reg_write, idex_dst_reg);
        exp_ctrl  = exp_stall ? '0 : ref_ctrl(instr);
        exp_imm   = ref_imm(instr);
        {exp_flush, exp_next_pc} = exp_stall ? {1'b0, pc}
                                             : ref_target(instr, pc, pc_plus_two, exp_read1);
    end

    task automatic value_error(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        $display("Test failed");
        $fatal(1, "value mismatch");
    endtask

    a_ctrl: assert property (@(posedge clk) disable iff (reset) ctrl == exp_ctrl)
        else value_error("ctrl", 16'($sampled(exp_ctrl)), 16'($sampled(ctrl)));
    a_read1: assert property (@(posedge clk) disable iff (reset) read1_data == exp_read1)
        else value_error("read1_data", $sampled(exp_read1), $sampled(read1_data));
    a_read2: assert property (@(posedge clk) disable iff (reset) read2_data == exp_read2)
        else value_error("read2_data", $sampled(exp_read2), $sampled(read2_data));
    a_imm: assert property (@(posedge clk) disable iff (reset) imm_ext == exp_imm)
        else value_error("imm_ext", $sampled(exp_imm), $sampled(imm_ext));
    a_next_pc: assert property (@(posedge clk) disable iff (reset) next_pc == exp_next_pc)
        else value_error("next_pc", $sampled(exp_next_pc), $sampled(next_pc));
    a_flush: assert property (@(posedge clk) disable iff (reset) if_flush == exp_flush)
        else value_error("if_flush", 16'($sampled(exp_flush)), 16'($sampled(if_flush)));
    a_pc_we: assert property (@(posedge clk) disable iff (reset) pc_write_en == !exp_stall)
        else value_error("pc_write_en", 16'(!$sampled(exp_stall)), 16'($sampled(pc_write_en)));
    a_ifid_we: assert property (@(posedge clk) disable iff (reset) ifid_write_en == !exp_stall)
        else value_error("ifid_write_en", 16'(!$sampled(exp_stall)),
                         16'($sampled(ifid_write_en)));

    // new instruction at a random even pc
    task automatic step(input logic [15:0] ins);
        logic [15:0] p;
        p = rand16() << 1;
        @(posedge clk);
        instr       <= ins;
        pc          <= p;
        pc_plus_two <= p + 16'd2;
    endtask

    task automatic set_idex(input logic [1:0] kind, input logic [2:0] dst);
        idex_mem_en    <= kind[1];
        idex_mem_wr    <= (kind == IDEX_STORE);
        idex_reg_write <= (kind == IDEX_ALU) || (kind == IDEX_LOAD);
        idex_dst_reg   <= dst;
    endtask

    task automatic set_wb(input logic en, input logic [2:0] dst, input logic [15:0] data);
        wb_write_en <= en;
        wb_dst_reg  <= dst;
        wb_data     <= data;
    endtask

    task automatic wait_fetch_release(input int limit);
        int n;
        n = 0;
        while (!pc_write_en) begin
            if (n == limit) begin
                $display("stall did not clear within %0d cycles after id/ex emptied", limit);
                $display("Test failed");
                $fatal(1, "timeout");
            end
            n++;
            @(posedge clk);
        end
    endtask

    task automatic stall_then_release(input logic [15:0] ins, input logic [1:0] kind,
                                      input logic [2:0] dst);
        step(ins);
        set_idex(kind, dst);
        // same instruction stays in if/id while held
        repeat (2) @(posedge clk);
        set_idex(IDEX_IDLE, 3'd0);
        wait_fetch_release(4);
    endtask

    task automatic register_traffic();
        logic [15:0] r;
        for (int i = 0; i < `REG_COUNT; i++) begin
            // rs names the register being written
            step({NOP, 3'(i), 3'(rand16()), 5'd0});
            set_wb(1'b1, 3'(i), rand16());
        end
        for (int i = 0; i < 24; i++) begin
            r = rand16();
            step({NOP, r[10:0]});
            set_wb(r[0], r[4:2], rand16());
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            step({NOP, 3'(i), 3'(i + 1), 5'd0});
            set_wb(1'b0, 3'd0, 16'd0);
        end
    endtask

    task automatic branch_sweep();
        logic [4:0]  ops [8];
        logic [15:0] r;
        logic [15:0] value;
        ops = '{BEQZ, BNEZ, BLTZ, BGEZ, J, JAL, JR, JALR};
        for (int k = 0; k < 8; k++) begin
            for (int c = 0; c < 6; c++) begin
                r = rand16();
                value = rand16();
                if (c % 3 == 0) value = 16'd0;
                else if (c % 3 == 1) value = value | 16'h8000;
                else value = (value & 16'h7fff) | 16'd1;
                // rs value arrives through the write-back bypass
                step({ops[k], r[10:0]});
                set_wb(1'b1, r[10:8], value);
            end
        end
        step({NOP, 11'd0});
        set_wb(1'b0, 3'd0, 16'd0);
    endtask

    task automatic hazard_cases();
        logic [15:0] r;
        r = rand16();
        stall_then_release({ADDI, r[10:0]}, IDEX_LOAD, r[10:8]);
        stall_then_release({RTYPE, r[10:0]}, IDEX_LOAD, r[7:5]);
        stall_then_release({ST, r[10:0]}, IDEX_LOAD, r[7:5]);
        stall_then_release({BEQZ, r[10:0]}, IDEX_ALU, r[10:8]);
        stall_then_release({JR, r[10:0]}, IDEX_LOAD, r[10:8]);
        // store producer and non-matching load do not hold fetch
        step({ADDI, r[10:0]});
        set_idex(IDEX_STORE, r[10:8]);
        step({ADDI, r[10:0]});
        set_idex(IDEX_LOAD, r[10:8] + 3'd1);
        for (int i = 0; i < 64; i++) begin
            r = rand16();
            step({r[15:11], r[10:0]});
            set_idex(2'(rand16()), r[0] ? r[10:8] : r[7:5]);
        end
        step({NOP, 11'd0});
        set_idex(IDEX_IDLE, 3'd0);
    endtask

    initial begin
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        // every register should read back zero
        for (int i = 0; i < `REG_COUNT; i++) begin
            step({NOP, 3'(i), 3'(`REG_COUNT - 1 - i), 5'd0});
        end
        register_traffic();
        for (int op = 0; op < 32; op++) begin
            for (int f = 0; f < 4; f++) begin
                step({5'(op), 9'(rand16()), 2'(f)});
            end
        end
        branch_sweep();
        hazard_cases();
        repeat (2) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_stage
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // from if/id
    input  logic [`WORD_W-1:0]    instr,
    input  logic [`WORD_W-1:0]    pc,
    input  logic [`WORD_W-1:0]    pc_plus_two,
    // from id/ex
    input  logic                  idex_mem_en,
    input  logic                  idex_mem_wr,
    input  logic                  idex_reg_write,
    input  logic [`REG_SEL_W-1:0] idex_dst_reg,
    // from write-back
    input  logic                  wb_write_en,
    input  logic [`REG_SEL_W-1:0] wb_dst_reg,
    input  logic [`WORD_W-1:0]    wb_data,
    output ctrl_t                 ctrl,
    output logic [`WORD_W-1:0]    read1_data,
    output logic [`WORD_W-1:0]    read2_data,
    output logic [`WORD_W-1:0]    imm_ext,
    output logic [`WORD_W-1:0]    next_pc,
    output logic                  if_flush,
    output logic                  pc_write_en,
    output logic                  ifid_write_en
);

    logic [`REG_SEL_W-1:0] rs;
    logic [`REG_SEL_W-1:0] rt;
    ctrl_t                 normal_ctrl;
    logic                  uses_rs;
    logic                  uses_rt;
    logic                  sign_ext;
    logic                  is_branch;
    logic                  is_jump;
    logic                  is_jump_reg;
    logic                  stall;

    assign rs = instr[10:8];
    assign rt = instr[7:5];

    control_decoder u_control_decoder (
        .instr(instr), .normal_ctrl(normal_ctrl), .uses_rs(uses_rs), .uses_rt(uses_rt),
        .sign_ext(sign_ext), .is_branch(is_branch), .is_jump(is_jump),
        .is_jump_reg(is_jump_reg)
    );

    register_file u_register_file (
        .clk(clk), .reset(reset), .read1_sel(rs), .read2_sel(rt),
        .write_sel(wb_dst_reg), .write_en(wb_write_en), .write_data(wb_data),
        .read1_data(read1_data), .read2_data(read2_data)
    );

    hazard_detect u_hazard_detect (
        .rs(rs), .rt(rt), .uses_rs(uses_rs), .uses_rt(uses_rt), .is_branch(is_branch),
        .is_jump_reg(is_jump_reg), .idex_mem_en(idex_mem_en), .idex_mem_wr(idex_mem_wr),
        .idex_reg_write(idex_reg_write), .idex_dst_reg(idex_dst_reg), .stall(stall)
    );

    branch_resolve u_branch_resolve (
        .instr(instr), .pc(pc), .pc_plus_two(pc_plus_two), .rs_data(read1_data),
        .sign_ext(sign_ext), .is_branch(is_branch), .is_jump(is_jump),
        .is_jump_reg(is_jump_reg), .stall(stall), .next_pc(next_pc), .imm_ext(imm_ext),
        .if_flush(if_flush)
    );

    // bubble into id/ex while fetch holds
    assign ctrl          = stall ? '0 : normal_ctrl;
    assign pc_write_en   = !stall;
    assign ifid_write_en = !stall;

    // a stall must keep fetch on the same pc with no flush
    a_stall_holds_fetch: assert property (
        @(posedge clk) disable iff (reset)
        stall |-> (next_pc == pc) && !if_flush
    ) else $error("stall did not hold fetch on the same pc");

endmodule

// File: verilog/branch_resolve.sv
`timescale 1ns/1ps
`include "decode_settings.svh"

module branch_resolve
    import decode_pkg::*;
(
    input  logic [`WORD_W-1:0] instr,
    input  logic [`WORD_W-1:0] pc,
    input  logic [`WORD_W-1:0] pc_plus_two,
    input  logic [`WORD_W-1:0] rs_data,
    input  logic               sign_ext,
    input  logic               is_branch,
    input  logic               is_jump,
    input  logic               is_jump_reg,
    input  logic               stall,
    output logic [`WORD_W-1:0] next_pc,
    output logic [`WORD_W-1:0] imm_ext,
    output logic               if_flush
);

    opcode_e            opcode;
    logic [`WORD_W-1:0] imm5;
    logic [`WORD_W-1:0] imm8;
    logic [`WORD_W-1:0] imm11;
    logic               sign8;
    logic               halt;
    logic               cond;
    logic               taken;
    logic [`WORD_W-1:0] branch_target;
    logic [`WORD_W-1:0] jump_target;
    logic [`WORD_W-1:0] reg_target;

    assign opcode = opcode_e'(instr[15:11]);
    assign halt   = (opcode == HALT);

    // control transfer offsets are always signed
    assign sign8 = sign_ext || is_branch || is_jump_reg;

    assign imm5  = {{(`WORD_W-5){sign_ext && instr[4]}}, instr[4:0]};
    assign imm8  = {{(`WORD_W-8){sign8 && instr[7]}}, instr[7:0]};
    assign imm11 = {{(`WORD_W-11){instr[10]}}, instr[10:0]};

    always_comb begin
        case (opcode)
            ADDI, SUBI, XORI, ANDNI, ST, LD: imm_ext = imm5;
            LBI, BEQZ, BNEZ, BLTZ, BGEZ, JR, JALR: imm_ext = imm8;
            J, JAL: imm_ext = imm11;
            default: imm_ext = '0;
        endcase
    end

    // condition on rs only, no second operand
    always_comb begin
        case (opcode)
            BEQZ: cond = (rs_data == '0);
            BNEZ: cond = (rs_data != '0);
            BLTZ: cond = rs_data[`WORD_W-1];
            BGEZ: cond = !rs_data[`WORD_W-1];
            default: cond = 1'b0;
        endcase
    end

    assign taken = is_branch && cond;

    assign branch_target = pc_plus_two + imm8;
    assign jump_target   = pc_plus_two + imm11;
    assign reg_target    = rs_data + imm8;

    always_comb begin
        if (stall || halt) begin
            next_pc = pc;
        end else if (taken) begin
            next_pc = branch_target;
        end else if (is_jump) begin
            next_pc = jump_target;
        end else if (is_jump_reg) begin
            next_pc = reg_target;
        end else begin
            next_pc = pc_plus_two;
        end

        // flush on any taken redirect, even one landing on pc_plus_two
        if_flush = !stall && !halt && (taken || is_jump || is_jump_reg);
    end

endmodule

// File: verilog/hazard_detect.sv
`timescale 1ns/1ps
`include "decode_settings.svh"

module hazard_detect (
    input  logic [`REG_SEL_W-1:0] rs,
    input  logic [`REG_SEL_W-1:0] rt,
    input  logic                  uses_rs,
    input  logic                  uses_rt,
    input  logic                  is_branch,
    input  logic                  is_jump_reg,
    input  logic                  idex_mem_en,
    input  logic                  idex_mem_wr,
    input  logic                  idex_reg_write,
    input  logic [`REG_SEL_W-1:0] idex_dst_reg,
    output logic                  stall
);

    logic idex_is_load;
    logic load_use;
    logic branch_operand;

    assign idex_is_load = idex_mem_en && !idex_mem_wr;

    always_comb begin
        // load data is not there until after mem
        load_use = idex_is_load &&
                   ((uses_rs && (idex_dst_reg == rs)) ||
                    (uses_rt && (idex_dst_reg == rt)));

        // rs is compared here in decode, so any producer in ex is too late
        branch_operand = (is_branch || is_jump_reg) &&
                         idex_reg_write && (idex_dst_reg == rs);

        stall = load_use || branch_operand;
    end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps
`include "decode_settings.svh"

module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`REG_SEL_W-1:0] read1_sel,
    input  logic [`REG_SEL_W-1:0] read2_sel,
    input  logic [`REG_SEL_W-1:0] write_sel,
    input  logic                  write_en,
    input  logic [`WORD_W-1:0]    write_data,
    output logic [`WORD_W-1:0]    read1_data,
    output logic [`WORD_W-1:0]    read2_data
);

    logic [`WORD_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_sel] <= write_data;
        end
    end

    logic bypass1;
    logic bypass2;

    // write-back in the same cycle wins over the stored value
    assign bypass1 = write_en && (write_sel == read1_sel);
    assign bypass2 = write_en && (write_sel == read2_sel);

    assign read1_data = bypass1 ? write_data : regs[read1_sel];
    assign read2_data = bypass2 ? write_data : regs[read2_sel];

    // an unknown write would poison the register and its bypass reader
    a_write_data_known: assert property (
        @(posedge clk) disable iff (reset)
        write_en |-> !$isunknown(write_data)
    ) else $error("register write with unknown data to r%0d", write_sel);

endmodule

// File: verilog/control_decoder.sv
`timescale 1ns/1ps
`include "decode_settings.svh"

module control_decoder
    import decode_pkg::*;
(
    input  logic [`WORD_W-1:0] instr,
    output ctrl_t              normal_ctrl,
    output logic               uses_rs,
    output logic               uses_rt,
    output logic               sign_ext,
    output logic               is_branch,
    output logic               is_jump,
    output logic               is_jump_reg
);

    opcode_e               opcode;
    logic [`REG_SEL_W-1:0] rs;
    logic [`REG_SEL_W-1:0] rt;
    logic [`REG_SEL_W-1:0] rd;

    assign opcode = opcode_e'(instr[15:11]);
    assign rs     = instr[10:8];
    assign rt     = instr[7:5];
    assign rd     = instr[4:2];

    always_comb begin
        // anything not listed below falls through as a nop
        normal_ctrl = '0;
        uses_rs     = 1'b0;
        uses_rt     = 1'b0;
        sign_ext    = 1'b1;
        is_branch   = 1'b0;
        is_jump     = 1'b0;
        is_jump_reg = 1'b0;

        case (opcode)
            HALT: begin
                normal_ctrl.halt = 1'b1;
            end
            ADDI, SUBI, XORI, ANDNI: begin
                // low two opcode bits line up with alu_op_e
                normal_ctrl.reg_write_en = 1'b1;
                normal_ctrl.alu_src_imm  = 1'b1;
                normal_ctrl.alu_op       = alu_op_e'(instr[12:11]);
                normal_ctrl.reg_src      = ALU;
                normal_ctrl.dst_reg      = rt;
                uses_rs                  = 1'b1;
                // logical immediates are zero extended
                sign_ext                 = (opcode == ADDI) || (opcode == SUBI);
            end
            RTYPE: begin
                normal_ctrl.reg_write_en = 1'b1;
                normal_ctrl.alu_op       = alu_op_e'(instr[1:0]);
                normal_ctrl.reg_src      = ALU;
                normal_ctrl.dst_reg      = rd;
                uses_rs                  = 1'b1;
                uses_rt                  = 1'b1;
            end
            LD: begin
                // address is rs + imm5
                normal_ctrl.reg_write_en = 1'b1;
                normal_ctrl.mem_en       = 1'b1;
                normal_ctrl.alu_src_imm  = 1'b1;
                normal_ctrl.alu_op       = ADD;
                normal_ctrl.reg_src      = MEM;
                normal_ctrl.dst_reg      = rt;
                uses_rs                  = 1'b1;
            end
            ST: begin
                // rt carries the store data
                normal_ctrl.mem_en      = 1'b1;
                normal_ctrl.mem_wr      = 1'b1;
                normal_ctrl.alu_src_imm = 1'b1;
                normal_ctrl.alu_op      = ADD;
                uses_rs                 = 1'b1;
                uses_rt                 = 1'b1;
            end
            LBI: begin
                normal_ctrl.reg_write_en = 1'b1;
                normal_ctrl.reg_src      = IMM;
                normal_ctrl.dst_reg      = rs;
            end
            BEQZ, BNEZ, BLTZ, BGEZ: begin
                uses_rs   = 1'b1;
                is_branch = 1'b1;
            end
            J: begin
                is_jump = 1'b1;
            end
            JAL: begin
                // link register is r7
                normal_ctrl.reg_write_en = 1'b1;
                normal_ctrl.reg_src      = PC_PLUS_TWO;
                normal_ctrl.dst_reg      = 3'd7;
                is_jump                  = 1'b1;
            end
            JR: begin
                uses_rs     = 1'b1;
                is_jump_reg = 1'b1;
            end
            JALR: begin
                normal_ctrl.reg_write_en = 1'b1;
                normal_ctrl.reg_src      = PC_PLUS_TWO;
                normal_ctrl.dst_reg      = 3'd7;
                uses_rs                  = 1'b1;
                is_jump_reg              = 1'b1;
            end
            default: begin
                normal_ctrl = '0;
            end
        endcase
    end

endmodule

// File: verilog/decode_pkg.sv
`include "decode_settings.svh"

package decode_pkg;

    // major opcodes, instr[15:11]
    typedef enum logic [4:0] {
        HALT  = 5'b00000,
        NOP   = 5'b00001,
        J     = 5'b00100,
        JR    = 5'b00101,
        JAL   = 5'b00110,
        JALR  = 5'b00111,
        ADDI  = 5'b01000,
        SUBI  = 5'b01001,
        XORI  = 5'b01010,
        ANDNI = 5'b01011,
        BEQZ  = 5'b01100,
        BNEZ  = 5'b01101,
        BLTZ  = 5'b01110,
        BGEZ  = 5'b01111,
        ST    = 5'b10000,
        LD    = 5'b10001,
        LBI   = 5'b11000,
        RTYPE = 5'b11011
    } opcode_e;

    // same order as the low opcode bits and the rtype function field
    typedef enum logic [1:0] {
        ADD  = 2'b00,
        SUB  = 2'b01,
        XOR  = 2'b10,
        ANDN = 2'b11
    } alu_op_e;

    // write-back source select
    typedef enum logic [1:0] {
        ALU         = 2'b00,
        MEM         = 2'b01,
        PC_PLUS_TWO = 2'b10,
        IMM         = 2'b11
    } reg_src_e;

    typedef struct packed {
        logic                  reg_write_en;
        logic                  mem_en;
        logic                  mem_wr;
        logic                  alu_src_imm;
        alu_op_e               alu_op;
        reg_src_e              reg_src;
        logic [`REG_SEL_W-1:0] dst_reg;
        logic                  halt;
    } ctrl_t;

endpackage

// File: verilog/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// data path and instruction width
`define WORD_W 16

// architectural registers r0..r7
`define REG_COUNT 8

// bits needed to name one register
`define REG_SEL_W 3

`endif
